//--- Makefile
# Verilator build and run for the video output stage testbench

VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP := video_out_tb
FILELIST := tb.f
BUILD_DIR := obj_dir

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard bench/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator exit status is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/video_tb_vectors.svh
// Rows need vec_t and the W_* write modes declared before the include, and fill rows must stay blanked
`ifndef VIDEO_TB_VECTORS_SVH
`define VIDEO_TB_VECTORS_SVH

// columns: wmode, waddr, wdata, vga_on, rnd {nib,stb,line,pix}, tv_stb, tv_pix, vga_pix,
// mode {tv_blank,vga_blank,tv_hires,vga_hires}, nib_sel, palsel, vga_line, tst, hold
localparam int NUM_VEC = 30;

localparam vec_t VECTORS [NUM_VEC] = '{
	// reset state, blank beats tst
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0000, 1'b0, 8'h00, 8'h00, 4'b0100, 2'd0, 4'h0, 1'b0, 3'd7, 10'd3},
	'{W_FILL, 8'h00, 15'h0000, 1'b1, 4'b0001, 1'b0, 8'h00, 8'h00, 4'b0100, 2'd0, 4'h0, 1'b0, 3'd0, 10'd256},
	// 0x10 and 0x11 have fine 0, 0x20 has coarse 3 with fine 7 and 4
	'{W_ONE, 8'h10, 15'h4118, 1'b1, 4'b0000, 1'b0, 8'h00, 8'h10, 4'b0100, 2'd0, 4'h0, 1'b0, 3'd0, 10'd1},
	'{W_ONE, 8'h11, 15'h6008, 1'b1, 4'b0000, 1'b0, 8'h00, 8'h10, 4'b0100, 2'd0, 4'h0, 1'b0, 3'd0, 10'd1},
	'{W_ONE, 8'h20, 15'h7F87, 1'b1, 4'b0000, 1'b0, 8'h00, 8'h10, 4'b0100, 2'd0, 4'h0, 1'b0, 3'd0, 10'd1},
	'{W_ONE, 8'h21, 15'h2D41, 1'b1, 4'b0000, 1'b0, 8'h00, 8'h10, 4'b0100, 2'd0, 4'h0, 1'b0, 3'd0, 10'd1},
	// VGA lores, TV blank and hires held high but unused
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0000, 1'b0, 8'h00, 8'h10, 4'b1010, 2'd0, 4'h0, 1'b0, 3'd0, 10'd4},
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0000, 1'b0, 8'h00, 8'h11, 4'b1010, 2'd0, 4'h0, 1'b1, 3'd0, 10'd4},
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0010, 1'b0, 8'h00, 8'h20, 4'b1010, 2'd0, 4'h0, 1'b0, 3'd0, 10'd8},
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0010, 1'b0, 8'h00, 8'h21, 4'b1010, 2'd0, 4'h0, 1'b0, 3'd0, 10'd8},
	// write and read 0x10 in one cycle
	'{W_ONE, 8'h10, 15'h1A5A, 1'b1, 4'b0000, 1'b0, 8'h00, 8'h10, 4'b1010, 2'd0, 4'h0, 1'b0, 3'd0, 10'd1},
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0000, 1'b0, 8'h00, 8'h10, 4'b1010, 2'd0, 4'h0, 1'b0, 3'd0, 10'd2},
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0011, 1'b0, 8'h00, 8'h00, 4'b1010, 2'd0, 4'h0, 1'b0, 3'd0, 10'd48},
	// VGA hires, nibble select bit 0 only
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0000, 1'b0, 8'h00, 8'hA5, 4'b0001, 2'd0, 4'h3, 1'b0, 3'd0, 10'd2},
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0000, 1'b0, 8'h00, 8'hA5, 4'b0001, 2'd1, 4'h3, 1'b1, 3'd0, 10'd2},
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0000, 1'b0, 8'h00, 8'hA5, 4'b0001, 2'd2, 4'h3, 1'b0, 3'd0, 10'd2},
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b1011, 1'b0, 8'h00, 8'h00, 4'b0001, 2'd0, 4'h9, 1'b0, 3'd0, 10'd24},
	// TV path, capture on the strobe and hold after it
	'{W_NONE, 8'h00, 15'h0000, 1'b0, 4'b0000, 1'b1, 8'h42, 8'h00, 4'b0101, 2'd0, 4'h0, 1'b0, 3'd0, 10'd1},
	'{W_NONE, 8'h00, 15'h0000, 1'b0, 4'b0000, 1'b0, 8'h99, 8'h00, 4'b0101, 2'd0, 4'h0, 1'b0, 3'd0, 10'd4},
	'{W_NONE, 8'h00, 15'h0000, 1'b0, 4'b0000, 1'b1, 8'hC7, 8'h00, 4'b0110, 2'd1, 4'h5, 1'b0, 3'd0, 10'd2},
	'{W_NONE, 8'h00, 15'h0000, 1'b0, 4'b0000, 1'b0, 8'h00, 8'h00, 4'b0110, 2'd2, 4'h5, 1'b1, 3'd0, 10'd3},
	'{W_NONE, 8'h00, 15'h0000, 1'b0, 4'b1101, 1'b0, 8'h00, 8'h00, 4'b0101, 2'd0, 4'h0, 1'b0, 3'd0, 10'd32},
	'{W_NONE, 8'h00, 15'h0000, 1'b0, 4'b1101, 1'b0, 8'h00, 8'h00, 4'b0110, 2'd0, 4'hA, 1'b0, 3'd0, 10'd24},
	// blanking on each source with all inversions on
	'{W_NONE, 8'h00, 15'h0000, 1'b0, 4'b0101, 1'b0, 8'h00, 8'h00, 4'b1000, 2'd0, 4'h0, 1'b0, 3'd7, 10'd8},
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0011, 1'b0, 8'h00, 8'h00, 4'b0100, 2'd0, 4'h0, 1'b0, 3'd7, 10'd8},
	// test inversion per channel
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0011, 1'b0, 8'h00, 8'h00, 4'b0000, 2'd0, 4'h0, 1'b0, 3'd1, 10'd8},
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0011, 1'b0, 8'h00, 8'h00, 4'b0000, 2'd0, 4'h0, 1'b0, 3'd2, 10'd8},
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0011, 1'b0, 8'h00, 8'h00, 4'b0000, 2'd0, 4'h0, 1'b0, 3'd4, 10'd8},
	'{W_NONE, 8'h00, 15'h0000, 1'b0, 4'b1101, 1'b0, 8'h00, 8'h00, 4'b0000, 2'd0, 4'h0, 1'b0, 3'd7, 10'd12},
	'{W_NONE, 8'h00, 15'h0000, 1'b1, 4'b0000, 1'b0, 8'h00, 8'h00, 4'b0100, 2'd0, 4'h0, 1'b0, 3'd0, 10'd4}
};

`endif

//--- bench/video_out_tb.sv
// Expected levels come from a model of the colour rules fed by the vector table, which writes the whole palette before any unblanked read
`timescale 1ns/1ps
`default_nettype none

module video_out_tb;

	import video_color_pkg::*;
	import video_mode_pkg::*;

	// palette write behaviour of a table row
	localparam logic [1:0] W_NONE = 2'd0;
	localparam logic [1:0] W_ONE = 2'd1;
	localparam logic [1:0] W_FILL = 2'd2;

	typedef struct packed {
		logic [1:0] wmode;
		logic [7:0] waddr;
		logic [COLOR_W-1:0] wdata;
		logic vga_on;
		logic [3:0] rnd;
		logic tv_stb;
		logic [7:0] tv_pix;
		logic [7:0] vga_pix;
		logic [3:0] mode;
		logic [1:0] nib_sel;
		logic [3:0] palsel;
		logic vga_line;
		logic [2:0] tst;
		logic [9:0] hold;
	} vec_t;

	`include "video_tb_vectors.svh"

	logic clk;
	logic rst;
	logic vga_on;
	logic tv_stb;
	pal_idx_t tv_pix;
	pal_idx_t vga_pix;
	logic tv_blank;
	logic vga_blank;
	logic tv_hires;
	logic vga_hires;
	logic [NIB_SEL_W-1:0] nib_sel;
	logic [PALSEL_W-1:0] palsel;
	logic vga_line;
	logic [2:0] tst;
	logic cram_we;
	pal_idx_t cram_addr;
	logic [COLOR_W-1:0] cram_data;
	logic [DAC_W-1:0] red_even;
	logic [DAC_W-1:0] red_odd;
	logic [DAC_W-1:0] grn_even;
	logic [DAC_W-1:0] grn_odd;
	logic [DAC_W-1:0] blu_even;
	logic [DAC_W-1:0] blu_odd;

	// model state
	logic [COLOR_W-1:0] shadow [256];
	pal_idx_t tv_hold;
	logic [1:0] model_ph;
	logic [15:0] lfsr;
	logic [11:0] exp_q [$];
	int cycles;
	int cycle_limit;

	video_out dut0 (
		.clk(clk),
		.rst(rst),
		.vga_on(vga_on),
		.tv_stb(tv_stb),
		.tv_pix(tv_pix),
		.vga_pix(vga_pix),
		.tv_blank(tv_blank),
		.vga_blank(vga_blank),
		.tv_hires(tv_hires),
		.vga_hires(vga_hires),
		.nib_sel(nib_sel),
		.palsel(palsel),
		.vga_line(vga_line),
		.tst(tst),
		.cram_we(cram_we),
		.cram_addr(cram_addr),
		.cram_data(cram_data),
		.red_even(red_even),
		.red_odd(red_odd),
		.grn_even(grn_even),
		.grn_odd(grn_odd),
		.blu_even(blu_even),
		.blu_odd(blu_odd)
	);

	always #10 clk = ~clk;

	// one Galois step with taps for x^16+x^14+x^13+x^11+1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// n random bits with one LFSR step per bit
	task automatic take_bits(input int n, output logic [7:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			v = {v[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// palette fill word in which every address bit shows up
	function automatic logic [COLOR_W-1:0] fill_word(input logic [7:0] a);
		return {a, a[6:0]} ^ 15'h2B6D;
	endfunction

	// one channel slot is the inverted coarse level plus one on a set pattern bit below 3
	function automatic logic [1:0] level_of(input logic [4:0] chan, input logic inv,
		input logic [2:0] pos);
		logic [1:0] coarse;
		logic [7:0] pat;
		logic [1:0] lvl;
		coarse = chan[4:3] ^ {inv, inv};
		pat = PWM_PATTERNS[chan[2:0]];
		lvl = coarse;
		if (coarse != 2'd3 && pat[pos])
			lvl = coarse + 2'd1;
		return lvl;
	endfunction

	// six levels packed as red, green, blue with even above odd
	function automatic logic [11:0] expect_levels(input logic [COLOR_W-1:0] w,
		input logic blank_v, input logic [2:0] tst_v, input logic [1:0] phase);
		logic [11:0] e;
		e = '0;
		if (!blank_v)
		begin
			e[11:10] = level_of(w[14:10], tst_v[1], {phase, 1'b0});
			e[9:8] = level_of(w[14:10], tst_v[1], {phase, 1'b1});
			e[7:6] = level_of(w[9:5], tst_v[2], {phase, 1'b0});
			e[5:4] = level_of(w[9:5], tst_v[2], {phase, 1'b1});
			e[3:2] = level_of(w[4:0], tst_v[0], {phase, 1'b0});
			e[1:0] = level_of(w[4:0], tst_v[0], {phase, 1'b1});
		end
		return e;
	endfunction

	task automatic check_value(input string name, input logic [DAC_W-1:0] expected,
		input logic [DAC_W-1:0] actual);
		if (actual !== expected)
		begin
			$display("Error: %s expected %h got %h at cycle %0d", name, expected, actual, cycles);
			$display("TESTS FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic compare_outputs();
		logic [11:0] e;
		e = exp_q.pop_front();
		check_value("red_even", e[11:10], red_even);
		check_value("red_odd", e[9:8], red_odd);
		check_value("grn_even", e[7:6], grn_even);
		check_value("grn_odd", e[5:4], grn_odd);
		check_value("blu_even", e[3:2], blu_even);
		check_value("blu_odd", e[1:0], blu_odd);
	endtask

	// drive one cycle of a row and queue the levels it must produce two edges later
	task automatic drive_cycle(input vec_t v, input int k);
		logic [7:0] bits;
		pal_idx_t pix;
		pal_idx_t idx;
		logic hires;
		logic nib;
		logic blank_v;
		logic [1:0] ph;
		logic [1:0] phase;
		cram_we = (v.wmode != W_NONE);
		cram_addr = (v.wmode == W_FILL) ? v.waddr + 8'(k) : v.waddr;
		cram_data = (v.wmode == W_FILL) ? fill_word(cram_addr) : v.wdata;
		vga_on = v.vga_on;
		tv_stb = v.tv_stb;
		tv_pix = v.tv_pix;
		vga_pix = v.vga_pix;
		{tv_blank, vga_blank, tv_hires, vga_hires} = v.mode;
		nib_sel = v.nib_sel;
		palsel = v.palsel;
		vga_line = v.vga_line;
		tst = v.tst;
		if (v.rnd[0])
		begin
			take_bits(8, bits);
			vga_pix = bits;
			take_bits(8, bits);
			tv_pix = bits;
		end
		if (v.rnd[1])
		begin
			take_bits(1, bits);
			vga_line = bits[0];
		end
		if (v.rnd[2])
		begin
			take_bits(1, bits);
			tv_stb = bits[0];
		end
		if (v.rnd[3])
		begin
			take_bits(2, bits);
			nib_sel = bits[1:0];
		end

		// TV source uses the pixel captured at an earlier strobe
		pix = vga_on ? vga_pix : tv_hold;
		hires = vga_on ? vga_hires : tv_hires;
		nib = vga_on ? nib_sel[0] : nib_sel[1];
		blank_v = vga_on ? vga_blank : tv_blank;
		idx = pix;
		if (hires)
			idx = {palsel, (nib ? pix[3:0] : pix[7:4])};
		// counter has stepped once more by the time the palette word is read
		ph = model_ph + 2'd1;
		phase = {(vga_on ? vga_line : ph[1]), ph[0]};
		exp_q.push_back(expect_levels(shadow[idx], blank_v, tst, phase));

		// edge updates where the write lands after the read
		if (cram_we)
			shadow[cram_addr] = cram_data;
		if (tv_stb)
			tv_hold = tv_pix;
		model_ph = model_ph + 2'd1;
	endtask

	// limit worked out from the table in the main process
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("Timeout: %0d clock cycles passed and the vectors did not finish", cycles);
			$display("TESTS FAILED");
			$fatal(1, "simulation timeout");
		end
	end

	initial
	begin
		int r;
		int k;
		clk = 1'b0;
		rst = 1'b1;
		vga_on = 1'b1;
		tv_stb = 1'b0;
		tv_pix = '0;
		vga_pix = '0;
		tv_blank = 1'b1;
		vga_blank = 1'b1;
		tv_hires = 1'b0;
		vga_hires = 1'b0;
		nib_sel = '0;
		palsel = '0;
		vga_line = 1'b0;
		tst = '0;
		cram_we = 1'b0;
		cram_addr = '0;
		cram_data = '0;
		lfsr = 16'd41;
		tv_hold = '0;
		model_ph = '0;
		cycles = 0;
		cycle_limit = 50;
		for (r = 0; r < NUM_VEC; r++)
			cycle_limit += int'(VECTORS[r].hold);
		// reset leaves the outputs at zero for two more cycles
		exp_q.push_back(12'd0);
		exp_q.push_back(12'd0);
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		for (r = 0; r < NUM_VEC; r++)
		begin
			for (k = 0; k < int'(VECTORS[r].hold); k++)
			begin
				compare_outputs();
				drive_cycle(VECTORS[r], k);
				@(posedge clk);
				#2;
			end
		end
		// drain the pipeline
		compare_outputs();
		@(posedge clk);
		#2;
		compare_outputs();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/palette_ram.sv
// Array has no reset and no init, so contents are undefined until the CPU writes them
`timescale 1ns/1ps
`default_nettype none

module palette_ram (
	input wire clk,
	input wire we,
	input wire video_mode_pkg::pal_idx_t waddr,
	input wire [video_color_pkg::COLOR_W-1:0] wdata,
	input wire video_mode_pkg::pal_idx_t raddr,
	output video_color_pkg::color_word_t rdata
);

	import video_color_pkg::*;
	import video_mode_pkg::*;

	// one entry per palette index
	color_word_t mem [2**PAL_IDX_W];

	// CPU write port
	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr].raw <= wdata;
	end

	// registered read
	// same address in the same cycle gives the old entry
	always_ff @(posedge clk)
	begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

//--- rtl/pixel_select.sv
// TV pixels are held from the last tv_stb cycle, the index is combinational and needs a registered sink
`timescale 1ns/1ps
`default_nettype none

module pixel_select (
	input wire clk,
	input wire rst,
	input wire vga_on,
	input wire tv_stb,
	input wire video_mode_pkg::pal_idx_t tv_pix,
	input wire video_mode_pkg::pal_idx_t vga_pix,
	input wire tv_blank,
	input wire vga_blank,
	input wire tv_hires,
	input wire vga_hires,
	input wire [video_mode_pkg::NIB_SEL_W-1:0] nib_sel,
	input wire [video_mode_pkg::PALSEL_W-1:0] palsel,
	output video_mode_pkg::pal_idx_t pal_idx,
	output logic blank
);

	import video_mode_pkg::*;

	pal_idx_t tv_pix_q;
	pix_src_t src;
	pal_idx_t pix;
	logic hires;
	logic nib;
	logic [NIB_W-1:0] nibble;

	// TV pixel capture, held between strobes
	always_ff @(posedge clk)
	begin
		if (rst)
			tv_pix_q <= '0;
		else if (tv_stb)
			tv_pix_q <= tv_pix;
	end

	assign src = vga_on ? SRC_VGA : SRC_TV;

	// source muxing of pixel, blank, mode and nibble select
	always_comb
	begin
		case (src)
			SRC_VGA:
			begin
				pix = vga_pix;
				blank = vga_blank;
				hires = vga_hires;
				nib = nib_sel[NIB_SEL_VGA];
			end
			default:
			begin
				pix = tv_pix_q;
				blank = tv_blank;
				hires = tv_hires;
				nib = nib_sel[NIB_SEL_TV];
			end
		endcase
	end

	// hires shows one nibble per pixel slot
	assign nibble = (nib == NIB_HIGH) ? pix[PAL_IDX_W-1:NIB_W] : pix[NIB_W-1:0];

	// bank from palsel on top in hires
	assign pal_idx = hires ? {palsel, nibble} : pix;

endmodule

`default_nettype wire

//--- rtl/pwm_dither.sv
// Control inputs must share the cycle with the palette address, and each clock yields one even and one odd level
`timescale 1ns/1ps
`default_nettype none

module pwm_dither (
	input wire clk,
	input wire rst,
	input wire video_color_pkg::color_word_t color,
	input wire blank,
	input wire vga_on,
	input wire vga_line,
	input wire [2:0] tst,
	output logic [video_color_pkg::DAC_W-1:0] red_even,
	output logic [video_color_pkg::DAC_W-1:0] red_odd,
	output logic [video_color_pkg::DAC_W-1:0] grn_even,
	output logic [video_color_pkg::DAC_W-1:0] grn_odd,
	output logic [video_color_pkg::DAC_W-1:0] blu_even,
	output logic [video_color_pkg::DAC_W-1:0] blu_odd
);

	import video_color_pkg::*;

	logic blank_d;
	logic vga_on_d;
	logic vga_line_d;
	logic [2:0] tst_d;
	logic [1:0] ph;
	logic [1:0] phase;
	color_word_t pix;

	// coarse level, raised by one where the pattern bit is set
	// level 3 is the top of the DAC and stays put
	function automatic logic [DAC_W-1:0] dither_level(input chan_t c, input logic [2:0] pos);
		logic bump;
		bump = PWM_PATTERNS[c.fine][pos] && (c.coarse != '1);
		return bump ? c.coarse + COARSE_W'(1) : c.coarse;
	endfunction

	// align controls with the registered palette read
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			blank_d <= 1'b1;
			vga_on_d <= 1'b0;
			vga_line_d <= 1'b0;
			tst_d <= '0;
		end
		else
		begin
			blank_d <= blank;
			vga_on_d <= vga_on;
			vga_line_d <= vga_line;
			tst_d <= tst;
		end
	end

	// free-running phase counter
	always_ff @(posedge clk)
	begin
		if (rst)
			ph <= '0;
		else
			ph <= ph + 2'd1;
	end

	// VGA ties the upper phase bit to the line parity
	assign phase = {vga_on_d ? vga_line_d : ph[1], ph[0]};

	// test inversion of the coarse bits, then blanking
	always_comb
	begin
		pix = color;
		pix.ch.red.coarse = pix.ch.red.coarse ^ {COARSE_W{tst_d[1]}};
		pix.ch.grn.coarse = pix.ch.grn.coarse ^ {COARSE_W{tst_d[2]}};
		pix.ch.blu.coarse = pix.ch.blu.coarse ^ {COARSE_W{tst_d[0]}};
		if (blank_d)
			pix.raw = '0;
	end

	// even slot uses pattern bit {phase,0}, odd slot {phase,1}
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			red_even <= '0;
			red_odd <= '0;
			grn_even <= '0;
			grn_odd <= '0;
			blu_even <= '0;
			blu_odd <= '0;
		end
		else
		begin
			red_even <= dither_level(pix.ch.red, {phase, 1'b0});
			red_odd <= dither_level(pix.ch.red, {phase, 1'b1});
			grn_even <= dither_level(pix.ch.grn, {phase, 1'b0});
			grn_odd <= dither_level(pix.ch.grn, {phase, 1'b1});
			blu_even <= dither_level(pix.ch.blu, {phase, 1'b0});
			blu_odd <= dither_level(pix.ch.blu, {phase, 1'b1});
		end
	end

endmodule

`default_nettype wire

//--- rtl/video_color_pkg.sv
// Palette words are 15 bits, red in the top five, each channel a 2-bit DAC level over a 3-bit PWM fine part
`default_nettype none

package video_color_pkg;

	// width of one DAC output level
	localparam int DAC_W = 2;

	// coarse part drives the DAC directly
	localparam int COARSE_W = DAC_W;

	// fine part picks one of the PWM patterns
	localparam int FINE_W = 3;

	localparam int CHAN_W = COARSE_W + FINE_W;

	// three channels per palette entry
	localparam int COLOR_W = 3 * CHAN_W;

	// one colour channel, coarse level in the upper bits
	typedef struct packed {
		logic [COARSE_W-1:0] coarse;
		logic [FINE_W-1:0] fine;
	} chan_t;

	// channel view of a palette entry
	typedef struct packed {
		chan_t red;
		chan_t grn;
		chan_t blu;
	} rgb_t;

	// raw view is what the CPU writes, channel view is what the dither reads
	typedef union packed {
		logic [COLOR_W-1:0] raw;
		rgb_t ch;
	} color_word_t;

	// pattern k carries k set bits spread over the eight half-clock slots
	localparam logic [7:0] PWM_PATTERNS [0:7] = '{
		8'b00000000,
		8'b00000001,
		8'b01000001,
		8'b01000101,
		8'b10100101,
		8'b10100111,
		8'b11010111,
		8'b11011111
	};

endpackage

`default_nettype wire

//--- rtl/video_mode_pkg.sv
// Pixel indices are 8 bits wide and hires mode uses a 4-bit palette bank with one pixel nibble
`default_nettype none

package video_mode_pkg;

	// palette index width, fixes the palette depth at 256
	localparam int PAL_IDX_W = 8;

	// upper index bits supplied by palsel in hires
	localparam int PALSEL_W = 4;

	// lower index bits taken from one pixel nibble in hires
	localparam int NIB_W = PAL_IDX_W - PALSEL_W;

	// palette index as it leaves the pixel source
	typedef logic [PAL_IDX_W-1:0] pal_idx_t;

	// pixel stream feeding the palette
	typedef enum logic {
		SRC_TV = 1'b0,
		SRC_VGA = 1'b1
	} pix_src_t;

	// position of the nibble select bit for each source
	localparam int NIB_SEL_VGA = 0;
	localparam int NIB_SEL_TV = 1;

	// width of the nibble select input
	localparam int NIB_SEL_W = 2;

	// nibble select value 0 takes the high nibble
	localparam logic NIB_HIGH = 1'b0;

endpackage

`default_nettype wire

//--- rtl/video_out.sv
// Latency is two clocks from pixel inputs to levels, plus one for TV pixels; DDR output of even and odd is left to the pads
`timescale 1ns/1ps
`default_nettype none

module video_out (
	input wire clk,
	input wire rst,
	input wire vga_on,
	input wire tv_stb,
	input wire video_mode_pkg::pal_idx_t tv_pix,
	input wire video_mode_pkg::pal_idx_t vga_pix,
	input wire tv_blank,
	input wire vga_blank,
	input wire tv_hires,
	input wire vga_hires,
	input wire [video_mode_pkg::NIB_SEL_W-1:0] nib_sel,
	input wire [video_mode_pkg::PALSEL_W-1:0] palsel,
	input wire vga_line,
	input wire [2:0] tst,
	input wire cram_we,
	input wire video_mode_pkg::pal_idx_t cram_addr,
	input wire [video_color_pkg::COLOR_W-1:0] cram_data,
	output logic [video_color_pkg::DAC_W-1:0] red_even,
	output logic [video_color_pkg::DAC_W-1:0] red_odd,
	output logic [video_color_pkg::DAC_W-1:0] grn_even,
	output logic [video_color_pkg::DAC_W-1:0] grn_odd,
	output logic [video_color_pkg::DAC_W-1:0] blu_even,
	output logic [video_color_pkg::DAC_W-1:0] blu_odd
);

	import video_color_pkg::*;
	import video_mode_pkg::*;

	pal_idx_t pal_idx;
	logic blank;
	color_word_t color;

	// source and index selection
	pixel_select u_pixel_select (
		.clk(clk),
		.rst(rst),
		.vga_on(vga_on),
		.tv_stb(tv_stb),
		.tv_pix(tv_pix),
		.vga_pix(vga_pix),
		.tv_blank(tv_blank),
		.vga_blank(vga_blank),
		.tv_hires(tv_hires),
		.vga_hires(vga_hires),
		.nib_sel(nib_sel),
		.palsel(palsel),
		.pal_idx(pal_idx),
		.blank(blank)
	);

	// CPU palette, read by the pixel index
	palette_ram u_palette_ram (
		.clk(clk),
		.we(cram_we),
		.waddr(cram_addr),
		.wdata(cram_data),
		.raddr(pal_idx),
		.rdata(color)
	);

	// blank and phase enter with the palette address
	pwm_dither u_pwm_dither (
		.clk(clk),
		.rst(rst),
		.color(color),
		.blank(blank),
		.vga_on(vga_on),
		.vga_line(vga_line),
		.tst(tst),
		.red_even(red_even),
		.red_odd(red_odd),
		.grn_even(grn_even),
		.grn_odd(grn_odd),
		.blu_even(blu_even),
		.blu_odd(blu_odd)
	);

endmodule

`default_nettype wire

//--- tb.f
+incdir+bench
rtl/video_color_pkg.sv
rtl/video_mode_pkg.sv
rtl/pixel_select.sv
rtl/palette_ram.sv
rtl/pwm_dither.sv
rtl/video_out.sv
bench/video_out_tb.sv
